//--- hdl/fec_consts.svh
`ifndef FEC_CONSTS_SVH
`define FEC_CONSTS_SVH

// Code geometry

`define RS_N 6       // Symbols per codeword
`define RS_K 4       // Data symbols per codeword

// Field

`define SYM_SIZE 4   // GF(2^4) symbol width
`define GF_POLY 5'h13  // x^4 + x + 1

// Erasure patterns

`define NUM_H 15     // One recovery matrix per erased pair
`define ERR_LOC_W 4  // Codes 15 and above are illegal

`endif

//--- hdl/fec_pkg.sv
package fec_pkg;

`include "fec_consts.svh"

    typedef logic [`SYM_SIZE-1:0] sym_t;
    typedef logic [$clog2(`RS_N)-1:0] pos_t;  // Codeword position
    typedef sym_t [`RS_K-1:0] rs_word_t;      // Symbol k sits in slot k
    typedef rs_word_t [`RS_K-1:0] rs_hmat_t;  // Indexed [row][column]

    typedef struct packed {
        rs_hmat_t h_matrix;
        rs_word_t word;
    } rs_job_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic sym_t gf_mul(sym_t a, sym_t b);
        sym_t prod;
        logic [`SYM_SIZE:0] shifted;
        prod = '0;
        shifted = {1'b0, a};
        for (int i = 0; i < `SYM_SIZE; i++) begin
            if (b[i]) prod ^= shifted[`SYM_SIZE-1:0];
            shifted = shifted << 1;
            if (shifted[`SYM_SIZE]) shifted ^= `GF_POLY;  // Reduce back into the field
        end
        return prod;
    endfunction

    function automatic sym_t gf_inv(sym_t a);
        sym_t inv;
        inv = '0;  // Zero has no inverse
        for (int i = 1; i < 2**`SYM_SIZE; i++) begin
            if (gf_mul(a, sym_t'(i)) == sym_t'(1)) inv = sym_t'(i);
        end
        return inv;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Generator and recovery matrices
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic rs_word_t gen_row(int r);
        rs_word_t row;
        sym_t pw;
        row = '0;
        pw = sym_t'(1);
        for (int k = 0; k < `RS_K; k++) begin
            if (r < `RS_K) begin
                row[k] = (k == r) ? sym_t'(1) : sym_t'(0);  // Systematic part
            end else if (r == `RS_K) begin
                row[k] = sym_t'(1);                         // Plain sum parity
            end else begin
                row[k] = pw;                                // Weighted by alpha^k
            end
            pw = gf_mul(pw, sym_t'(2));
        end
        return row;
    endfunction

    // Pairs are numbered in lexicographic order starting at (0,1)
    function automatic pos_t [1:0] erased_pair(int code);
        pos_t [1:0] pair;
        int n;
        pair = '0;
        n = 0;
        for (int a = 0; a < `RS_N; a++) begin
            for (int b = a + 1; b < `RS_N; b++) begin
                if (n == code) begin
                    pair[0] = pos_t'(a);
                    pair[1] = pos_t'(b);
                end
                n++;
            end
        end
        return pair;
    endfunction

    function automatic rs_hmat_t recovery_matrix(int code);
        pos_t [1:0] pair;
        rs_hmat_t m;
        rs_hmat_t inv;
        rs_word_t tmp;
        sym_t scale;
        sym_t f;
        int row;
        int piv;
        pair = erased_pair(code);
        m = '0;
        inv = '0;
        row = 0;
        for (int p = 0; p < `RS_N; p++) begin
            if (p != pair[0] && p != pair[1] && row < `RS_K) begin
                m[row] = gen_row(p);  // Surviving rows in ascending order
                row++;
            end
        end
        for (int r = 0; r < `RS_K; r++) inv[r][r] = sym_t'(1);
        // Gauss-Jordan elimination with inv tracking the row operations
        for (int c = 0; c < `RS_K; c++) begin
            piv = c;
            for (int r = `RS_K - 1; r >= c; r--) begin
                if (m[r][c] != '0) piv = r;
            end
            tmp = m[c];
            m[c] = m[piv];
            m[piv] = tmp;
            tmp = inv[c];
            inv[c] = inv[piv];
            inv[piv] = tmp;
            scale = gf_inv(m[c][c]);
            for (int k = 0; k < `RS_K; k++) begin
                m[c][k] = gf_mul(m[c][k], scale);
                inv[c][k] = gf_mul(inv[c][k], scale);
            end
            for (int r = 0; r < `RS_K; r++) begin
                if (r != c) begin
                    f = m[r][c];
                    for (int k = 0; k < `RS_K; k++) begin
                        m[r][k] ^= gf_mul(f, m[c][k]);
                        inv[r][k] ^= gf_mul(f, inv[c][k]);
                    end
                end
            end
        end
        return inv;
    endfunction

endpackage

//--- hdl/rs_decode_h_select.sv
`timescale 1ns/1ps
`include "fec_consts.svh"

module rs_decode_h_select
    import fec_pkg::*;
#(
    parameter int DATA_BYTE_WID = 8,  // Must be a multiple of RS_K
    parameter int NUM_THREADS = 2     // Nibbles per byte
) (
    input  logic clk,
    input  logic rst_n,

    input  logic [DATA_BYTE_WID/`RS_K-1:0][`RS_K-1:0][NUM_THREADS*`SYM_SIZE-1:0] data_in,
    input  logic [`ERR_LOC_W-1:0] err_loc,
    input  logic data_in_valid,
    output logic data_in_ready,

    output rs_job_t [DATA_BYTE_WID/`RS_K*NUM_THREADS-1:0] jobs,
    output logic job_valid,
    input  logic job_ready
);

    localparam int NUM_CW = DATA_BYTE_WID / `RS_K;
    localparam int NUM_LANES = NUM_CW * NUM_THREADS;

    typedef rs_hmat_t [`NUM_H-1:0] h_table_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Recovery matrix table with one entry per erased pair
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic h_table_t build_h_table();
        h_table_t tbl;
        for (int h = 0; h < `NUM_H; h++) begin
            tbl[h] = recovery_matrix(h);
        end
        return tbl;
    endfunction

    localparam h_table_t H_TABLE = build_h_table();

    rs_hmat_t h_sel;
    rs_job_t [NUM_LANES-1:0] jobs_next;

    assign h_sel = H_TABLE[err_loc];  // Codes of NUM_H and above never arrive

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Split each codeword group into per-thread lane jobs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int g = 0; g < NUM_CW; g++) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                jobs_next[g*NUM_THREADS+t].h_matrix = h_sel;
                for (int k = 0; k < `RS_K; k++) begin
                    jobs_next[g*NUM_THREADS+t].word[k] =
                        data_in[g][k][t*`SYM_SIZE +: `SYM_SIZE];  // Nibble t of survivor k
                end
            end
        end
    end

    assign data_in_ready = !job_valid || job_ready;  // Slot empty or draining this cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            job_valid <= 1'b0;
        end else if (data_in_ready) begin
            job_valid <= data_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_in_valid && data_in_ready) begin
            jobs <= jobs_next;
        end
    end

endmodule

//--- hdl/rs_decode.sv
`timescale 1ns/1ps
`include "fec_consts.svh"

module rs_decode
    import fec_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    input  rs_job_t job,
    input  logic job_valid,
    output logic job_ready,

    output rs_word_t result,
    output logic res_valid,
    input  logic res_ready
);

    rs_word_t prod;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Matrix times surviving-symbol vector over GF(2^4)
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int r = 0; r < `RS_K; r++) begin
            prod[r] = '0;
            for (int c = 0; c < `RS_K; c++) begin
                prod[r] ^= gf_mul(job.h_matrix[r][c], job.word[c]);  // Field addition is XOR
            end
        end
    end

    assign job_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (job_ready) begin
            res_valid <= job_valid;
        end
    end

    // Result slot holds its value while the merge stage stalls
    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            result <= prod;
        end
    end

endmodule

//--- hdl/rs_decode_merge.sv
`timescale 1ns/1ps
`include "fec_consts.svh"

module rs_decode_merge
    import fec_pkg::*;
#(
    parameter int DATA_BYTE_WID = 8,
    parameter int NUM_THREADS = 2
) (
    input  logic clk,
    input  logic rst_n,

    input  rs_word_t [DATA_BYTE_WID/`RS_K*NUM_THREADS-1:0] results,
    input  logic res_valid,
    output logic res_ready,

    output logic [DATA_BYTE_WID/`RS_K-1:0][`RS_K-1:0][NUM_THREADS*`SYM_SIZE-1:0] data_out,
    output logic data_out_valid,
    input  logic data_out_ready
);

    localparam int NUM_CW = DATA_BYTE_WID / `RS_K;

    logic [NUM_CW-1:0][`RS_K-1:0][NUM_THREADS*`SYM_SIZE-1:0] bytes;

    // Lane g*NUM_THREADS+t feeds nibble t of group g as in the feeder split
    always_comb begin
        for (int g = 0; g < NUM_CW; g++) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                for (int k = 0; k < `RS_K; k++) begin
                    bytes[g][k][t*`SYM_SIZE +: `SYM_SIZE] = results[g*NUM_THREADS+t][k];
                end
            end
        end
    end

    assign res_ready = !data_out_valid || data_out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out_valid <= 1'b0;
        end else if (res_ready) begin
            data_out_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            data_out <= bytes;  // Stable until the consumer takes it
        end
    end

endmodule

//--- hdl/fec_decode.sv
`timescale 1ns/1ps
`include "fec_consts.svh"

module fec_decode
    import fec_pkg::*;
#(
    parameter int DATA_BYTE_WID = 8,  // Bytes per transfer
    parameter int NUM_THREADS = 2     // Symbols per byte and so the lane count
) (
    input  logic clk,
    input  logic rst_n,

    input  logic [DATA_BYTE_WID/`RS_K-1:0][`RS_K-1:0][NUM_THREADS*`SYM_SIZE-1:0] data_in,
    input  logic [`ERR_LOC_W-1:0] err_loc,
    input  logic data_in_valid,
    output logic data_in_ready,

    output logic [DATA_BYTE_WID/`RS_K-1:0][`RS_K-1:0][NUM_THREADS*`SYM_SIZE-1:0] data_out,
    output logic data_out_valid,
    input  logic data_out_ready
);

    localparam int NUM_LANES = DATA_BYTE_WID / `RS_K * NUM_THREADS;

    rs_job_t [NUM_LANES-1:0] jobs;
    logic job_valid;
    logic [NUM_LANES-1:0] lane_job_ready;  // Lanes run in lockstep so lane 0 speaks for all

    rs_word_t [NUM_LANES-1:0] results;
    logic [NUM_LANES-1:0] lane_res_valid;
    logic res_ready;

    rs_decode_h_select #(
        .DATA_BYTE_WID  (DATA_BYTE_WID),
        .NUM_THREADS    (NUM_THREADS)
    ) h_select0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .err_loc        (err_loc),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .jobs           (jobs),
        .job_valid      (job_valid),
        .job_ready      (lane_job_ready[0])
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One decode lane per codeword group and thread
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        rs_decode lane0 (
            .clk        (clk),
            .rst_n      (rst_n),
            .job        (jobs[l]),
            .job_valid  (job_valid),
            .job_ready  (lane_job_ready[l]),
            .result     (results[l]),
            .res_valid  (lane_res_valid[l]),
            .res_ready  (res_ready)
        );
    end

    rs_decode_merge #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .NUM_THREADS     (NUM_THREADS)
    ) merge0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .results         (results),
        .res_valid       (lane_res_valid[0]),
        .res_ready       (res_ready),
        .data_out        (data_out),
        .data_out_valid  (data_out_valid),
        .data_out_ready  (data_out_ready)
    );

endmodule

//--- test/fec_decode_asserts.sv
`timescale 1ns/1ps
`include "fec_consts.svh"

module fec_decode_asserts #(
    parameter int DATA_BYTE_WID = 8,
    parameter int NUM_THREADS = 2
) (
    input logic clk,
    input logic rst_n,
    input logic [`ERR_LOC_W-1:0] err_loc,
    input logic data_in_valid,
    input logic [DATA_BYTE_WID*NUM_THREADS*`SYM_SIZE-1:0] data_out,
    input logic data_out_valid,
    input logic data_out_ready
);

    int fail_count = 0;  // Read by the testbench at the end of the run

    // Only 15 erased pairs exist
    err_loc_legal: assert property (@(posedge clk) disable iff (!rst_n)
        data_in_valid |-> err_loc < `NUM_H)
        else begin
            fail_count++;
            $error("err_loc %0d has no recovery matrix", err_loc);
        end

    out_held_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
        else begin
            fail_count++;
            $error("data_out changed while stalled");
        end

    no_valid_in_reset: assert property (@(posedge clk) !rst_n |=> !data_out_valid)
        else begin
            fail_count++;
            $error("data_out_valid high during reset");
        end

endmodule

//--- test/fec_decode_tb.sv
`timescale 1ns/1ps
`include "fec_consts.svh"

module fec_decode_tb;

    localparam int DATA_BYTE_WID = 8;
    localparam int NUM_THREADS = 2;
    localparam int NUM_CW = DATA_BYTE_WID / `RS_K;
    localparam int MAX_CYCLES = 6000;  // About four times the full test run

    typedef logic [NUM_CW-1:0][`RS_K-1:0][NUM_THREADS*`SYM_SIZE-1:0] xfer_t;

    logic clk = 1'b0;
    logic rst_n;
    xfer_t data_in;
    logic [`ERR_LOC_W-1:0] err_loc;
    logic data_in_valid;
    logic data_in_ready;
    xfer_t data_out;
    logic data_out_valid;
    logic data_out_ready;

    xfer_t exp_q[$];   // Original data of every accepted transfer
    int acc_q[$];      // Cycle of each input transfer
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int errors_at_start = 0;
    bit check_latency = 1'b0;
    bit random_ready = 1'b0;

    fec_decode #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .NUM_THREADS     (NUM_THREADS)
    ) dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_in         (data_in),
        .err_loc         (err_loc),
        .data_in_valid   (data_in_valid),
        .data_in_ready   (data_in_ready),
        .data_out        (data_out),
        .data_out_valid  (data_out_valid),
        .data_out_ready  (data_out_ready)
    );

    bind fec_decode fec_decode_asserts #(
        .DATA_BYTE_WID  (DATA_BYTE_WID),
        .NUM_THREADS    (NUM_THREADS)
    ) asserts0 (.*);

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of the channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [`SYM_SIZE-1:0] times_alpha(logic [`SYM_SIZE-1:0] s, int k);
        logic [`SYM_SIZE:0] acc;
        acc = {1'b0, s};
        for (int i = 0; i < k; i++) begin
            acc = acc << 1;
            if (acc[`SYM_SIZE]) acc = acc ^ `GF_POLY;  // Fold x^4 back as x+1
        end
        return acc[`SYM_SIZE-1:0];
    endfunction

    // Encodes every lane and keeps the four survivors in ascending order
    function automatic xfer_t make_received(xfer_t data, int code);
        logic [`SYM_SIZE-1:0] cw [`RS_N];
        xfer_t rx;
        int first;
        int second;
        int n;
        int j;
        n = 0;
        first = 0;
        second = 1;
        for (int a = 0; a < `RS_N; a++) begin
            for (int b = a + 1; b < `RS_N; b++) begin
                if (n == code) begin
                    first = a;
                    second = b;
                end
                n++;
            end
        end
        rx = '0;
        for (int g = 0; g < NUM_CW; g++) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                cw[`RS_K] = '0;
                cw[`RS_K+1] = '0;
                for (int k = 0; k < `RS_K; k++) begin
                    cw[k] = data[g][k][t*`SYM_SIZE +: `SYM_SIZE];
                    cw[`RS_K] ^= cw[k];                    // Plain sum parity
                    cw[`RS_K+1] ^= times_alpha(cw[k], k);  // Weighted parity
                end
                j = 0;
                for (int p = 0; p < `RS_N; p++) begin
                    if (p != first && p != second) begin
                        rx[g][j][t*`SYM_SIZE +: `SYM_SIZE] = cw[p];
                        j++;
                    end
                end
            end
        end
        return rx;
    endfunction

    function automatic xfer_t rand_xfer();
        return {$urandom, $urandom};
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic send(input xfer_t data, input int code);
        data_in <= make_received(data, code);
        err_loc <= code[`ERR_LOC_W-1:0];
        data_in_valid <= 1'b1;
        @(posedge clk);
        while (!data_in_ready) @(posedge clk);
        exp_q.push_back(data);
        acc_q.push_back(cycle);
    endtask

    task automatic idle();
        data_in_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drain();
        data_in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("%s: %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (random_ready) begin
            data_out_ready <= $urandom_range(1, 0);
        end else begin
            data_out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin : compare_out
        int acc_cycle;
        if (rst_n && data_out_valid && data_out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: data_out arrived with no transfer outstanding", $time);
                errors++;
            end else begin
                acc_cycle = acc_q.pop_front();
                check_eq(data_out, exp_q.pop_front(), "data_out");
                if (check_latency) check_eq(cycle - acc_cycle, 3, "latency in cycles");
            end
        end
    end

    always @(posedge clk) begin : stall_watch
        bit stalled;
        xfer_t held;
        if (stalled) begin
            check_eq(data_out_valid, 1'b1, "data_out_valid held while stalled");
            check_eq(data_out, held, "data_out held while stalled");
        end
        stalled = rst_n && data_out_valid && !data_out_ready;
        held = data_out;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : run_tests
        int first_acc;
        int total;
        void'($urandom(32'hf297));
        rst_n = 1'b0;
        data_in = '0;
        err_loc = '0;
        data_in_valid = 1'b0;
        data_out_ready = 1'b1;

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i > 0) check_eq(data_out_valid, 1'b0, "data_out_valid during reset");
            if (i == 3) data_in_valid <= 1'b1;  // Input traffic must not leak through reset
            if (i == 7) data_in_valid <= 1'b0;
            if (i == 9) rst_n <= 1'b1;
        end
        @(posedge clk);
        check_eq(data_out_valid, 1'b0, "data_out_valid after reset");
        check_eq(data_in_ready, 1'b1, "data_in_ready after reset");
        test_done("reset");

        check_latency = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send(rand_xfer(), 14);
            idle();
        end
        drain();
        test_done("parity erased");

        for (int code = 0; code < `NUM_H; code++) begin
            for (int i = 0; i < 4; i++) send(rand_xfer(), code);
        end
        drain();
        test_done("all erasure patterns");

        send(rand_xfer(), $urandom_range(`NUM_H - 1, 0));
        first_acc = acc_q[$];
        for (int i = 1; i < 300; i++) send(rand_xfer(), $urandom_range(`NUM_H - 1, 0));
        check_eq(acc_q[$] - first_acc, 299, "cycles for 300 streamed transfers");
        drain();
        test_done("back to back");

        check_latency = 1'b0;
        random_ready = 1'b1;
        for (int i = 0; i < 300; i++) send(rand_xfer(), $urandom_range(`NUM_H - 1, 0));
        drain();
        random_ready = 1'b0;
        test_done("random back-pressure");

        total = errors + dut0.asserts0.fail_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, dut0.asserts0.fail_count);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/fec_pkg.sv
hdl/rs_decode_h_select.sv
hdl/rs_decode.sv
hdl/rs_decode_merge.sv
hdl/fec_decode.sv
test/fec_decode_asserts.sv
test/fec_decode_tb.sv
